/* mb_fetch_pkg.sv */
// Macroblock fetch shared definitions
// Beat, address and count types, the quantizer header layout as it
// sits in the low 240 bits of the header beat, the host command and
// status records, and the fixed per-plane bias values
`default_nettype none

package mb_fetch_pkg;

    localparam int BEAT_BYTES = 32;

    typedef logic [255:0] beat_t;
    typedef logic [31:0]  axi_addr_t;
    typedef logic [7:0]   mb_count_t;
    typedef logic [1:0]   axi_resp_t;

    // DC and AC entries of one quantizer table
    typedef struct packed {
        logic [7:0]  q_dc;
        logic [7:0]  q_ac;
        logic [15:0] iq_dc;
        logic [15:0] iq_ac;
        logic [7:0]  zthresh_dc;
        logic [7:0]  zthresh_ac;
    } qtable_t;

    // Header beat bits [239:0] with the y1 table at the top
    typedef struct packed {
        qtable_t    y1;
        qtable_t    y2;
        qtable_t    uv;
        logic [7:0] lambda_i16;
        logic [7:0] lambda_i4;
        logic [7:0] lambda_uv;
        logic [7:0] tlambda;
        logic [7:0] lambda_mode;
        logic [7:0] min_disto;
    } quant_params_t;

    typedef struct packed {
        axi_addr_t base;
        mb_count_t mb_count;
    } fetch_cmd_t;

    typedef struct packed {
        logic      error;
        mb_count_t mb_done;
    } fetch_status_t;

    // Bias tables are not carried in the header
    localparam logic [31:0] Y1_BIAS_DC = 32'h0000_c000;
    localparam logic [31:0] Y1_BIAS_AC = 32'h0000_dc00;
    localparam logic [31:0] Y2_BIAS_DC = 32'h0000_c000;
    localparam logic [31:0] Y2_BIAS_AC = 32'h0000_d800;
    localparam logic [31:0] UV_BIAS_DC = 32'h0000_dc00;
    localparam logic [31:0] UV_BIAS_AC = 32'h0000_e600;

endpackage

`default_nettype wire

/* mb_fifo.sv */
// Plane FIFO
// First-word-fall-through buffer for one beat-wide plane stream.
// The head word is always on dout while empty is low; rd pops it.
`default_nettype none

module mb_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr,
    input  mb_fetch_pkg::beat_t  din,
    input  wire                  rd,
    output mb_fetch_pkg::beat_t  dout,
    output logic                 full,
    output logic                 empty
);
    import mb_fetch_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    // Pop frees a slot, so a write into a full FIFO is fine then
    assign do_rd = rd && !empty;
    assign do_wr = wr && (!full || do_rd);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mb_read_ctrl.sv */
// Fetch read controller
// Takes one host command over the req/ack port, issues the AR bursts
// for the header and every macroblock back to back, then waits for
// the unpacker to finish each burst before raising ack with status
`default_nettype none

module mb_read_ctrl #(
    parameter int ID_WIDTH = 2
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmd_req,
    input  mb_fetch_pkg::fetch_cmd_t    cmd,
    output logic                        cmd_ack,
    output mb_fetch_pkg::fetch_status_t status,
    output logic                        arvalid,
    output mb_fetch_pkg::axi_addr_t     araddr,
    output logic [7:0]                  arlen,
    output logic [ID_WIDTH-1:0]         arid,
    input  wire                         arready,
    output logic                        cmd_start,
    output logic [ID_WIDTH-1:0]         expect_id,
    input  wire                         burst_done,
    input  wire                         rd_error
);
    import mb_fetch_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_DRAIN,
        S_ACK,
        S_RELEASE
    } state_t;

    // First burst covers header plus macroblock 0
    localparam axi_addr_t FIRST_STEP = axi_addr_t'(4 * BEAT_BYTES);
    localparam axi_addr_t MB_STEP    = axi_addr_t'(3 * BEAT_BYTES);

    state_t            state;
    fetch_cmd_t        cmd_q;
    mb_count_t         issued_cnt;
    mb_count_t         done_cnt;
    mb_count_t         done_nxt;
    logic [ID_WIDTH-1:0] seq_id;
    logic              ar_fire;

    assign cmd_start = (state == S_IDLE) && cmd_req;
    assign arvalid   = (state == S_ISSUE);
    assign ar_fire   = arvalid && arready;
    assign arlen     = (issued_cnt == '0) ? 8'd3 : 8'd2;
    assign arid      = seq_id;
    assign expect_id = seq_id;
    assign cmd_ack   = (state == S_ACK);
    assign status    = '{error: rd_error, mb_done: done_cnt};
    assign done_nxt  = done_cnt + mb_count_t'(burst_done);

    // --------------------------------------------------
    // Handshake and burst FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            issued_cnt <= '0;
            done_cnt   <= '0;
            seq_id     <= '0;
        end else begin
            if (cmd_start) begin
                done_cnt <= '0;
            end else begin
                done_cnt <= done_nxt;
            end
            case (state)
                S_IDLE: begin
                    if (cmd_req) begin
                        issued_cnt <= '0;
                        state      <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (ar_fire) begin
                        issued_cnt <= issued_cnt + 1'b1;
                        if (mb_count_t'(issued_cnt + 1'b1) == cmd_q.mb_count) begin
                            state <= S_DRAIN;
                        end
                    end
                end
                S_DRAIN: begin
                    if (done_nxt == cmd_q.mb_count) begin
                        state <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!cmd_req) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    seq_id <= seq_id + 1'b1;
                    state  <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Command copy and burst address
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            cmd_q  <= cmd;
            araddr <= cmd.base;
        end else if (ar_fire) begin
            araddr <= araddr + ((issued_cnt == '0) ? FIRST_STEP : MB_STEP);
        end
    end

endmodule

`default_nettype wire

/* mb_rdata_unpack.sv */
// Read data unpacker
// Walks the R channel beat order (header, then Y0/Y1/UV per
// macroblock), decodes the header into quantizer params, stages the
// luma beats and pushes all three planes on the UV beat
`default_nettype none

module mb_rdata_unpack #(
    parameter int ID_WIDTH = 2
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmd_start,
    input  wire  [ID_WIDTH-1:0]         expect_id,
    input  wire                         rvalid,
    input  mb_fetch_pkg::beat_t         rdata,
    input  wire  [ID_WIDTH-1:0]         rid,
    input  mb_fetch_pkg::axi_resp_t     rresp,
    input  wire                         rlast,
    input  wire                         y0_full,
    input  wire                         y1_full,
    input  wire                         uv_full,
    output logic                        rready,
    output logic                        burst_done,
    output logic                        rd_error,
    output mb_fetch_pkg::quant_params_t params,
    output logic                        fifo_wr,
    output mb_fetch_pkg::beat_t         y0_din,
    output mb_fetch_pkg::beat_t         y1_din,
    output mb_fetch_pkg::beat_t         uv_din
);
    import mb_fetch_pkg::*;

    typedef enum logic [1:0] {
        PH_HDR,
        PH_Y0,
        PH_Y1,
        PH_UV
    } phase_t;

    phase_t phase;
    beat_t  y0_q;
    beat_t  y1_q;
    logic   beat_acc;
    logic   any_full;

    // Only the UV beat waits for space in all three planes
    assign any_full   = y0_full || y1_full || uv_full;
    assign rready     = !((phase == PH_UV) && any_full);
    assign beat_acc   = rvalid && rready;
    assign burst_done = beat_acc && rlast;

    assign fifo_wr = beat_acc && (phase == PH_UV);
    assign y0_din  = y0_q;
    assign y1_din  = y1_q;
    assign uv_din  = rdata;

    // --------------------------------------------------
    // Beat phase
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_HDR;
        end else if (cmd_start) begin
            phase <= PH_HDR;
        end else if (beat_acc) begin
            case (phase)
                PH_HDR:  phase <= PH_Y0;
                PH_Y0:   phase <= PH_Y1;
                PH_Y1:   phase <= PH_UV;
                default: phase <= PH_Y0;
            endcase
        end
    end

    // Header decode and luma staging
    always_ff @(posedge clk) begin
        if (beat_acc) begin
            case (phase)
                PH_HDR:  params <= quant_params_t'(rdata[239:0]);
                PH_Y0:   y0_q <= rdata;
                PH_Y1:   y1_q <= rdata;
                default: ;
            endcase
        end
    end

    // Sticky for the whole command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_error <= 1'b0;
        end else if (cmd_start) begin
            rd_error <= 1'b0;
        end else if (beat_acc && ((rresp != '0) || (rid != expect_id))) begin
            rd_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* mb_fetch_top.sv */
// Macroblock fetch front end
// Host command port and AXI4 read channel in, quantizer params and
// three fall-through plane FIFOs (Y0, Y1, UV) out
`default_nettype none

module mb_fetch_top #(
    parameter int ID_WIDTH   = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmd_req,
    input  mb_fetch_pkg::fetch_cmd_t    cmd,
    output logic                        cmd_ack,
    output mb_fetch_pkg::fetch_status_t status,
    output logic                        arvalid,
    output mb_fetch_pkg::axi_addr_t     araddr,
    output logic [7:0]                  arlen,
    output logic [ID_WIDTH-1:0]         arid,
    input  wire                         arready,
    input  wire                         rvalid,
    input  mb_fetch_pkg::beat_t         rdata,
    input  wire  [ID_WIDTH-1:0]         rid,
    input  mb_fetch_pkg::axi_resp_t     rresp,
    input  wire                         rlast,
    output logic                        rready,
    output mb_fetch_pkg::quant_params_t params,
    input  wire                         y0_rd,
    output mb_fetch_pkg::beat_t         y0_dout,
    output logic                        y0_empty,
    input  wire                         y1_rd,
    output mb_fetch_pkg::beat_t         y1_dout,
    output logic                        y1_empty,
    input  wire                         uv_rd,
    output mb_fetch_pkg::beat_t         uv_dout,
    output logic                        uv_empty
);
    import mb_fetch_pkg::*;

    logic                cmd_start;
    logic [ID_WIDTH-1:0] expect_id;
    logic                burst_done;
    logic                rd_error;
    logic                fifo_wr;
    beat_t               y0_din;
    beat_t               y1_din;
    beat_t               uv_din;
    logic                y0_full;
    logic                y1_full;
    logic                uv_full;

    // --------------------------------------------------
    // Command and AR channel
    // --------------------------------------------------
    mb_read_ctrl #(
        .ID_WIDTH (ID_WIDTH)
    ) u_read_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .status     (status),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arid       (arid),
        .arready    (arready),
        .cmd_start  (cmd_start),
        .expect_id  (expect_id),
        .burst_done (burst_done),
        .rd_error   (rd_error)
    );

    // --------------------------------------------------
    // R channel and plane buffers
    // --------------------------------------------------
    mb_rdata_unpack #(
        .ID_WIDTH (ID_WIDTH)
    ) u_rdata_unpack (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .expect_id  (expect_id),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rid        (rid),
        .rresp      (rresp),
        .rlast      (rlast),
        .y0_full    (y0_full),
        .y1_full    (y1_full),
        .uv_full    (uv_full),
        .rready     (rready),
        .burst_done (burst_done),
        .rd_error   (rd_error),
        .params     (params),
        .fifo_wr    (fifo_wr),
        .y0_din     (y0_din),
        .y1_din     (y1_din),
        .uv_din     (uv_din)
    );

    mb_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_y0_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (y0_din),
        .rd    (y0_rd),
        .dout  (y0_dout),
        .full  (y0_full),
        .empty (y0_empty)
    );

    mb_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_y1_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (y1_din),
        .rd    (y1_rd),
        .dout  (y1_dout),
        .full  (y1_full),
        .empty (y1_empty)
    );

    mb_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_uv_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .din   (uv_din),
        .rd    (uv_rd),
        .dout  (uv_dout),
        .full  (uv_full),
        .empty (uv_empty)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
// Behavioral AXI4 read slave for the fetch testbench
// Queues AR bursts and returns them in order on R. Data is a fixed
// pattern of the beat address, except the one header beat the
// testbench stores. Optional random ready/valid gaps, SLVERR on one
// beat and a corrupted rid on one burst, counted per command
`default_nettype none

module tb_axi_mem #(
    parameter int ID_WIDTH = 2
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     gap_en,
    input  wire signed [31:0]       err_beat,
    input  wire signed [31:0]       bad_id_burst,
    input  mb_fetch_pkg::axi_addr_t hdr_addr,
    input  mb_fetch_pkg::beat_t     hdr_beat,
    input  wire                     arvalid,
    input  mb_fetch_pkg::axi_addr_t araddr,
    input  wire [7:0]               arlen,
    input  wire [ID_WIDTH-1:0]      arid,
    output logic                    arready,
    output logic                    rvalid,
    output mb_fetch_pkg::beat_t     rdata,
    output logic [ID_WIDTH-1:0]     rid,
    output mb_fetch_pkg::axi_resp_t rresp,
    output logic                    rlast,
    input  wire                     rready
);
    import mb_fetch_pkg::*;

    axi_addr_t           q_addr [$];
    logic [7:0]          q_len [$];
    logic [ID_WIDTH-1:0] q_id [$];
    logic [ID_WIDTH-1:0] last_id;
    logic                have_id;
    int                  cur_beat;
    int                  cmd_beat;
    int                  cmd_burst;
    axi_addr_t           beat_addr;

    // Word i of a beat is its address XOR i times the golden ratio constant
    function automatic beat_t pattern_beat(axi_addr_t addr);
        beat_t b;
        for (int i = 0; i < 8; i++) begin
            b[i*32 +: 32] = addr ^ (32'(i) * 32'h9e37_79b9);
        end
        return b;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rid     <= '0;
            rresp   <= '0;
            rlast   <= 1'b0;
            q_addr.delete();
            q_len.delete();
            q_id.delete();
            last_id   = '0;
            have_id   = 1'b0;
            cur_beat  = 0;
            cmd_beat  = 0;
            cmd_burst = 0;
        end else begin
            // --------------------------------------------------
            // A new arid on the AR side starts a new command
            // --------------------------------------------------
            if (arvalid && arready) begin
                if (!have_id || (arid != last_id)) begin
                    cmd_beat  = 0;
                    cmd_burst = 0;
                end
                have_id = 1'b1;
                last_id = arid;
                q_addr.push_back(araddr);
                q_len.push_back(arlen);
                q_id.push_back(arid);
            end
            arready <= gap_en ? (($urandom % 4) != 0) : 1'b1;

            // --------------------------------------------------
            // R side returns one burst at a time in AR order
            // --------------------------------------------------
            if (rvalid && rready) begin
                cmd_beat = cmd_beat + 1;
                if (rlast) begin
                    q_addr.delete(0);
                    q_len.delete(0);
                    q_id.delete(0);
                    cur_beat  = 0;
                    cmd_burst = cmd_burst + 1;
                end else begin
                    cur_beat = cur_beat + 1;
                end
            end
            // Beat holds while stalled
            if (!rvalid || rready) begin
                if ((q_addr.size() > 0) && (!gap_en || (($urandom % 3) != 0))) begin
                    beat_addr = q_addr[0] + axi_addr_t'(cur_beat * BEAT_BYTES);
                    rvalid <= 1'b1;
                    rdata  <= (beat_addr == hdr_addr) ? hdr_beat : pattern_beat(beat_addr);
                    rresp  <= (cmd_beat == err_beat) ? 2'b10 : 2'b00;
                    rid    <= (cmd_burst == bad_id_burst) ? (q_id[0] ^ ID_WIDTH'(1)) : q_id[0];
                    rlast  <= (cur_beat == int'(q_len[0]));
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mb_fetch.sv */
// Macroblock fetch testbench
// Directed tests of the fetch front end against a behavioral AXI read
// slave: single fetch, random slave gaps, FIFO back-pressure, SLVERR,
// wrong read ID and a clean command after an error
`default_nettype none

module tb_mb_fetch;
    import mb_fetch_pkg::*;

    localparam int          ID_W      = 2;
    localparam int          DEPTH     = 4;
    localparam int          TIMEOUT   = 4000;
    localparam logic [31:0] RAND_SEED = 32'hec6a_d1e5;

    logic            clk;
    logic            rst_n;
    logic            cmd_req;
    fetch_cmd_t      cmd;
    logic            cmd_ack;
    fetch_status_t   status;
    logic            arvalid;
    axi_addr_t       araddr;
    logic [7:0]      arlen;
    logic [ID_W-1:0] arid;
    logic            arready;
    logic            rvalid;
    beat_t           rdata;
    logic [ID_W-1:0] rid;
    axi_resp_t       rresp;
    logic            rlast;
    logic            rready;
    quant_params_t   params;
    logic [2:0]      plane_rd;
    beat_t           plane_dout [3];
    wire  [2:0]      plane_empty;
    logic            gap_en;
    int              err_beat;
    int              bad_id_burst;
    axi_addr_t       hdr_addr;
    beat_t           hdr_beat;
    int              cmd_count;
    int              ar_burst;

    mb_fetch_top #(
        .ID_WIDTH   (ID_W),
        .FIFO_DEPTH (DEPTH)
    ) mb_fetch_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .status   (status),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .arlen    (arlen),
        .arid     (arid),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rid      (rid),
        .rresp    (rresp),
        .rlast    (rlast),
        .rready   (rready),
        .params   (params),
        .y0_rd    (plane_rd[0]),
        .y0_dout  (plane_dout[0]),
        .y0_empty (plane_empty[0]),
        .y1_rd    (plane_rd[1]),
        .y1_dout  (plane_dout[1]),
        .y1_empty (plane_empty[1]),
        .uv_rd    (plane_rd[2]),
        .uv_dout  (plane_dout[2]),
        .uv_empty (plane_empty[2])
    );

    tb_axi_mem #(
        .ID_WIDTH (ID_W)
    ) axi_mem_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .gap_en       (gap_en),
        .err_beat     (err_beat),
        .bad_id_burst (bad_id_burst),
        .hdr_addr     (hdr_addr),
        .hdr_beat     (hdr_beat),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arid         (arid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rid          (rid),
        .rresp        (rresp),
        .rlast        (rlast),
        .rready       (rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Error exit and typed compares
    // --------------------------------------------------
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_beat(string name, beat_t exp, beat_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_params(string name, quant_params_t exp, quant_params_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_status(string name, fetch_status_t exp, fetch_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h actual %h", name, exp, act));
        end
    endtask

    // Address, length and ID of one AR request
    task automatic check_ar(string name, axi_addr_t exp_addr, logic [7:0] exp_len,
                            logic [ID_W-1:0] exp_id, axi_addr_t act_addr,
                            logic [7:0] act_len, logic [ID_W-1:0] act_id);
        if ({act_addr, act_len, act_id} !== {exp_addr, exp_len, exp_id}) begin
            abort_run($sformatf("Fail %s: expected %h/%h/%h actual %h/%h/%h", name,
                                exp_addr, exp_len, exp_id, act_addr, act_len, act_id));
        end
    endtask

    // Burst k starts at base for k = 0, else (1 + 3k) beats above it
    task automatic track_ar_request(string name, axi_addr_t base);
        axi_addr_t exp_addr;
        if (arvalid && arready) begin
            exp_addr = (ar_burst == 0) ? base :
                       base + axi_addr_t'((1 + 3 * ar_burst) * BEAT_BYTES);
            check_ar($sformatf("%s AR burst %0d", name, ar_burst), exp_addr,
                     (ar_burst == 0) ? 8'd3 : 8'd2, ID_W'(cmd_count),
                     araddr, arlen, arid);
            ar_burst++;
        end
    endtask

    // Word i of the memory pattern is address ^ (i * 0x9e3779b9)
    function automatic beat_t expected_beat(axi_addr_t addr);
        beat_t b;
        for (int i = 0; i < 8; i++) begin
            b[i*32 +: 32] = addr ^ (32'(i) * 32'h9e37_79b9);
        end
        return b;
    endfunction

    function automatic quant_params_t make_header(logic [7:0] s);
        return quant_params_t'({10{s, s ^ 8'h5a, s + 8'd17}});
    endfunction

    // --------------------------------------------------
    // One command with handshake, drain, status and params
    // --------------------------------------------------
    task automatic fetch_and_check(string name, axi_addr_t base, int n, quant_params_t hdr,
                                   bit gaps, bit slow, bit hold, int err_at, int bad_burst,
                                   bit exp_err);
        int            idx [3];
        int            cycles;
        bit            ack_seen;
        fetch_status_t exp_status;
        idx        = '{0, 0, 0};
        ack_seen   = 1'b0;
        ar_burst   = 0;
        exp_status = '{error: exp_err, mb_done: mb_count_t'(n)};
        @(posedge clk);
        gap_en       <= gaps;
        err_beat     <= err_at;
        bad_id_burst <= bad_burst;
        hdr_addr     <= base;
        hdr_beat     <= {16'hbeef, hdr};
        cmd          <= '{base: base, mb_count: mb_count_t'(n)};
        cmd_req      <= 1'b1;
        // Leave the FIFOs full until the UV beat stalls
        if (hold) begin
            cycles = 0;
            while (rready) begin
                @(posedge clk);
                track_ar_request(name, base);
                cycles++;
                if (cycles > TIMEOUT) begin
                    abort_run($sformatf("%s: rready never dropped with full FIFOs", name));
                end
            end
            if (cmd_ack) begin
                abort_run($sformatf("%s: ack raised while the FIFOs were stalled", name));
            end
        end
        cycles = 0;
        while (!ack_seen || (idx[0] < n) || (idx[1] < n) || (idx[2] < n)) begin
            @(posedge clk);
            track_ar_request(name, base);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("%s: timeout waiting for ack or plane data", name));
            end
            for (int p = 0; p < 3; p++) begin
                // A pop happens at this edge, so dout is the word leaving
                if (plane_rd[p] && !plane_empty[p]) begin
                    check_beat($sformatf("%s plane %0d word %0d", name, p, idx[p]),
                               expected_beat(base + axi_addr_t'((1 + 3 * idx[p] + p) *
                                                                BEAT_BYTES)),
                               plane_dout[p]);
                    idx[p]++;
                end
                plane_rd[p] <= (idx[p] < n) && (!slow || (($urandom % 4) == 0));
            end
            if (cmd_ack && !ack_seen) begin
                ack_seen = 1'b1;
                check_status($sformatf("%s status", name), exp_status, status);
            end
        end
        if (ar_burst != n) begin
            abort_run($sformatf("%s: %0d AR bursts issued for %0d macroblocks",
                                name, ar_burst, n));
        end
        check_params($sformatf("%s params", name), hdr, params);
        @(posedge clk);
        cmd_req <= 1'b0;
        if (plane_empty != 3'b111) begin
            abort_run($sformatf("%s: a plane FIFO holds extra words", name));
        end
        cycles = 0;
        while (cmd_ack) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("%s: ack stayed high after req dropped", name));
            end
        end
        cmd_count++;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic single_mb_fetch();
        fetch_and_check("single_mb", 32'h0000_1000, 1, make_header(8'h21),
                        1'b0, 1'b0, 1'b0, -1, -1, 1'b0);
    endtask

    task automatic gapped_fetch();
        fetch_and_check("random_gaps", 32'h0000_4000, 5, make_header(8'h37),
                        1'b1, 1'b0, 1'b0, -1, -1, 1'b0);
    endtask

    task automatic backpressure_fetch();
        fetch_and_check("backpressure", 32'h0001_0000, 8, make_header(8'h4c),
                        1'b1, 1'b1, 1'b1, -1, -1, 1'b0);
    endtask

    // Beat 5 of the command is Y1 of macroblock 1
    task automatic slverr_fetch();
        fetch_and_check("slverr_y1", 32'h0002_0000, 3, make_header(8'h65),
                        1'b0, 1'b0, 1'b0, 5, -1, 1'b1);
    endtask

    task automatic bad_rid_fetch();
        fetch_and_check("bad_rid", 32'h0003_0000, 3, make_header(8'h7a),
                        1'b1, 1'b0, 1'b0, -1, 1, 1'b1);
    endtask

    task automatic recovery_fetch();
        fetch_and_check("clean_after_error", 32'h0004_2000, 2, make_header(8'h93),
                        1'b1, 1'b1, 1'b0, -1, -1, 1'b0);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        cmd_count     = 0;
        ar_burst      = 0;
        rst_n        <= 1'b0;
        cmd_req      <= 1'b0;
        cmd          <= '0;
        plane_rd     <= '0;
        gap_en       <= 1'b0;
        err_beat     <= -1;
        bad_id_burst <= -1;
        hdr_addr     <= '0;
        hdr_beat     <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        single_mb_fetch();
        gapped_fetch();
        backpressure_fetch();
        slverr_fetch();
        bad_rid_fetch();
        recovery_fetch();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
mb_fetch_pkg.sv
mb_fifo.sv
mb_read_ctrl.sv
mb_rdata_unpack.sv
mb_fetch_top.sv
tb_axi_mem.sv
tb_mb_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the macroblock fetch testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f files.f --top-module tb_mb_fetch; then
    echo "Verilator build failed"
    exit 1
fi

if ! output="$(./obj_dir/Vtb_mb_fetch 2>&1)"; then
    echo "$output"
    echo "Simulation run returned an error status"
    exit 1
fi

echo "$output"

if grep -q "^Simulation PASSED$" <<< "$output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
